//--- hw/mhq_pkg.sv
/* Shared sizes and derived widths for the miss handling queue,
   request and fill record structs, opcode and CCU state enums */

package mhq_pkg;

    localparam int DATA_WIDTH      = 32;
    localparam int ADDR_WIDTH      = 32;
    localparam int MHQ_DEPTH       = 4;
    localparam int LINE_SIZE       = 32;
    localparam int WORD_SIZE       = 4;

    localparam int IDX_WIDTH       = $clog2(MHQ_DEPTH);
    localparam int OFFSET_WIDTH    = $clog2(LINE_SIZE);
    localparam int LINE_WIDTH      = LINE_SIZE * 8;
    // Upper address bits that name a cache line
    localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mhq_op_e;

    typedef struct packed {
        mhq_op_e                    op;
        logic [LINE_ADDR_WIDTH-1:0] line_addr;
        logic [OFFSET_WIDTH-1:0]    offset;
        logic [DATA_WIDTH-1:0]      wr_data;
        logic [WORD_SIZE-1:0]       byte_sel;
    } mhq_req_t;

    typedef struct packed {
        logic [IDX_WIDTH-1:0]  tag;
        logic                  dirty;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0] data;
    } mhq_fill_t;

    // Four-phase line fetch with the CCU
    typedef enum logic [1:0] {
        CS_IDLE    = 2'd0,
        CS_REQ     = 2'd1,
        CS_RELEASE = 2'd2,
        CS_DONE    = 2'd3
    } ccu_state_e;

endpackage

//--- hw/mhq_ptr.sv
/* Head and tail pointers of the miss queue with full and empty flags */

`timescale 1ns/1ps

module mhq_ptr (
    input  logic                          clk,
    input  logic                          n_rst,
    input  logic                          i_alloc,
    input  logic                          i_done,
    output logic [mhq_pkg::IDX_WIDTH-1:0] o_head_idx,
    output logic [mhq_pkg::IDX_WIDTH-1:0] o_tail_idx,
    output logic                          o_full,
    output logic                          o_empty
);

    // One extra wrap bit above the index
    logic [mhq_pkg::IDX_WIDTH:0] head_q;
    logic [mhq_pkg::IDX_WIDTH:0] tail_q;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (i_done) begin
                head_q <= head_q + 1'b1;
            end
            if (i_alloc) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    assign o_head_idx = head_q[mhq_pkg::IDX_WIDTH-1:0];
    assign o_tail_idx = tail_q[mhq_pkg::IDX_WIDTH-1:0];

    assign o_empty = (head_q == tail_q);
    assign o_full  = (o_head_idx == o_tail_idx) &&
                     (head_q[mhq_pkg::IDX_WIDTH] != tail_q[mhq_pkg::IDX_WIDTH]);

    // Lookup must stall new lines on full, and the CCU side only finishes valid heads
    a_no_alloc_full: assert property (@(posedge clk) disable iff (!n_rst) !(i_alloc && o_full));
    a_no_done_empty: assert property (@(posedge clk) disable iff (!n_rst) !(i_done && o_empty));

endmodule

//--- hw/mhq_lu.sv
/* Lookup stage of the miss queue: holds one request, matches its line
   against the queue entries and picks the entry tag */

`timescale 1ns/1ps

module mhq_lu (
    input  logic                                clk,
    input  logic                                n_rst,

    // Request input, valid/ready
    input  logic                                i_req_valid,
    input  mhq_pkg::mhq_req_t                   i_req,
    output logic                                o_req_ready,

    // Entry state from the execute stage
    input  logic [mhq_pkg::MHQ_DEPTH-1:0]       i_entry_valid,
    input  logic [mhq_pkg::LINE_ADDR_WIDTH-1:0] i_entry_addr [mhq_pkg::MHQ_DEPTH],
    input  logic [mhq_pkg::IDX_WIDTH-1:0]       i_tail_idx,
    input  logic                                i_full,

    // To the execute stage
    output logic                                o_ex_en,
    output logic                                o_ex_match,
    output logic [mhq_pkg::IDX_WIDTH-1:0]       o_ex_tag,
    output mhq_pkg::mhq_req_t                   o_ex_req
);

    logic                           valid_q;
    mhq_pkg::mhq_req_t              req_q;
    logic [mhq_pkg::MHQ_DEPTH-1:0]  hit;
    logic                           proceed;

    // Compare the held line against every valid entry
    always_comb begin
        for (int i = 0; i < mhq_pkg::MHQ_DEPTH; i++) begin
            hit[i] = i_entry_valid[i] && (i_entry_addr[i] == req_q.line_addr);
        end
    end

    // Matching entry wins, else a new entry at the tail
    always_comb begin
        o_ex_tag = i_tail_idx;
        for (int i = 0; i < mhq_pkg::MHQ_DEPTH; i++) begin
            if (hit[i]) begin
                o_ex_tag = (mhq_pkg::IDX_WIDTH)'(i);
            end
        end
    end

    assign o_ex_match = |hit;

    // Only a request that needs a fresh entry waits on a full queue
    assign proceed     = valid_q && (o_ex_match || !i_full);
    assign o_ex_en     = proceed;
    assign o_ex_req    = req_q;
    assign o_req_ready = !valid_q || proceed;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            valid_q <= 1'b0;
        end else if (o_req_ready) begin
            valid_q <= i_req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (o_req_ready && i_req_valid) begin
            req_q <= i_req;
        end
    end

    // Execute never holds two entries for one line
    a_single_hit: assert property (@(posedge clk) disable iff (!n_rst)
        valid_q |-> $onehot0(hit));

endmodule

//--- hw/mhq_ex.sv
/* Execute stage of the miss queue: entry array, store merging into entries,
   fill line merging with CCU data and the registered fill record */

`timescale 1ns/1ps

module mhq_ex (
    input  logic                                clk,
    input  logic                                n_rst,

    // From the lookup stage
    input  logic                                i_ex_en,
    input  logic                                i_ex_match,
    input  logic [mhq_pkg::IDX_WIDTH-1:0]       i_ex_tag,
    input  mhq_pkg::mhq_req_t                   i_ex_req,

    // Pointers and CCU completion
    input  logic [mhq_pkg::IDX_WIDTH-1:0]       i_head_idx,
    input  logic                                i_done,
    input  logic [mhq_pkg::LINE_WIDTH-1:0]      i_ccu_line,

    output logic                                o_alloc,
    output logic [mhq_pkg::MHQ_DEPTH-1:0]       o_entry_valid,
    output logic [mhq_pkg::LINE_ADDR_WIDTH-1:0] o_entry_addr [mhq_pkg::MHQ_DEPTH],
    output logic                                o_head_valid,
    output logic [mhq_pkg::ADDR_WIDTH-1:0]      o_head_addr,

    // Fill record
    output logic                                o_fill_en,
    output mhq_pkg::mhq_fill_t                  o_fill
);

    // Per-entry state
    logic [mhq_pkg::MHQ_DEPTH-1:0]       valid_q;
    logic [mhq_pkg::MHQ_DEPTH-1:0]       dirty_q;
    logic [mhq_pkg::LINE_ADDR_WIDTH-1:0] addr_q [mhq_pkg::MHQ_DEPTH];
    logic [mhq_pkg::LINE_WIDTH-1:0]      data_q [mhq_pkg::MHQ_DEPTH];
    logic [mhq_pkg::LINE_SIZE-1:0]       upd_q  [mhq_pkg::MHQ_DEPTH];

    logic                                is_store;
    logic                                ex_wr;
    logic [mhq_pkg::LINE_SIZE-1:0]       st_mask;
    logic [mhq_pkg::LINE_WIDTH-1:0]      st_data;
    logic                                ex_dirty;
    logic [mhq_pkg::LINE_WIDTH-1:0]      ex_data;
    logic [mhq_pkg::LINE_SIZE-1:0]       ex_upd;
    logic                                fill_merge;
    logic [mhq_pkg::LINE_WIDTH-1:0]      fill_data;
    logic [mhq_pkg::MHQ_DEPTH-1:0]       valid_next;

    assign is_store = (i_ex_req.op == mhq_pkg::OP_STORE);
    assign o_alloc  = i_ex_en && !i_ex_match;
    // Loads to an open line leave the entry untouched
    assign ex_wr    = o_alloc || (i_ex_en && is_store);

    // Place the store word into line byte lanes
    always_comb begin
        st_mask = '0;
        st_data = '0;
        for (int i = 0; i < mhq_pkg::LINE_SIZE; i++) begin
            for (int j = 0; j < mhq_pkg::WORD_SIZE; j++) begin
                if (is_store && i_ex_req.byte_sel[j] && (int'(i_ex_req.offset) + j == i)) begin
                    st_mask[i]        = 1'b1;
                    st_data[i*8 +: 8] = i_ex_req.wr_data[j*8 +: 8];
                end
            end
        end
    end

    // New entry contents; allocation starts from a clean mask
    always_comb begin
        ex_dirty = is_store || (!o_alloc && dirty_q[i_ex_tag]);
        ex_data  = data_q[i_ex_tag];
        ex_upd   = o_alloc ? '0 : upd_q[i_ex_tag];
        for (int i = 0; i < mhq_pkg::LINE_SIZE; i++) begin
            if (st_mask[i]) begin
                ex_data[i*8 +: 8] = st_data[i*8 +: 8];
                ex_upd[i]         = 1'b1;
            end
        end
    end

    // Store to the head line in the fill cycle
    assign fill_merge = i_ex_en && is_store && i_ex_match && (i_ex_tag == i_head_idx);

    // Byte priority: merging store, stored byte, CCU data
    always_comb begin
        for (int i = 0; i < mhq_pkg::LINE_SIZE; i++) begin
            if (fill_merge && st_mask[i]) begin
                fill_data[i*8 +: 8] = st_data[i*8 +: 8];
            end else if (upd_q[i_head_idx][i]) begin
                fill_data[i*8 +: 8] = data_q[i_head_idx][i*8 +: 8];
            end else begin
                fill_data[i*8 +: 8] = i_ccu_line[i*8 +: 8];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < mhq_pkg::MHQ_DEPTH; i++) begin
            valid_next[i] = (valid_q[i] || (o_alloc && int'(i_ex_tag) == i)) &&
                            !(i_done && int'(i_head_idx) == i);
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_wr) begin
            dirty_q[i_ex_tag] <= ex_dirty;
            addr_q[i_ex_tag]  <= i_ex_req.line_addr;
            data_q[i_ex_tag]  <= ex_data;
            upd_q[i_ex_tag]   <= ex_upd;
        end
    end

    assign o_entry_valid = valid_q;
    assign o_entry_addr  = addr_q;
    assign o_head_valid  = valid_q[i_head_idx];
    assign o_head_addr   = {addr_q[i_head_idx], {mhq_pkg::OFFSET_WIDTH{1'b0}}};

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_fill_en <= 1'b0;
        end else begin
            o_fill_en <= i_done;
        end
    end

    always_ff @(posedge clk) begin
        if (i_done) begin
            o_fill.tag   <= i_head_idx;
            o_fill.dirty <= dirty_q[i_head_idx] || fill_merge;
            o_fill.addr  <= o_head_addr;
            o_fill.data  <= fill_data;
        end
    end

    // The fetch FSM only completes a line that is still queued
    a_done_head_valid: assert property (@(posedge clk) disable iff (!n_rst)
        i_done |-> valid_q[i_head_idx]);

endmodule

//--- hw/ccu_req_fsm.sv
/* Four-phase line fetch FSM towards the CCU, latches the returned line */

`timescale 1ns/1ps

module ccu_req_fsm (
    input  logic                             clk,
    input  logic                             n_rst,
    input  logic                             i_head_valid,
    input  logic [mhq_pkg::ADDR_WIDTH-1:0]   i_head_addr,
    output logic                             o_ccu_req,
    output logic [mhq_pkg::ADDR_WIDTH-1:0]   o_ccu_addr,
    input  logic                             i_ccu_ack,
    input  logic [mhq_pkg::LINE_WIDTH-1:0]   i_ccu_data,
    output logic                             o_done,
    output logic [mhq_pkg::LINE_WIDTH-1:0]   o_ccu_line
);

    mhq_pkg::ccu_state_e            state_q;
    mhq_pkg::ccu_state_e            state_d;
    logic [mhq_pkg::ADDR_WIDTH-1:0] addr_q;
    logic [mhq_pkg::LINE_WIDTH-1:0] line_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            mhq_pkg::CS_IDLE: begin
                if (i_head_valid) begin
                    state_d = mhq_pkg::CS_REQ;
                end
            end
            mhq_pkg::CS_REQ: begin
                if (i_ccu_ack) begin
                    state_d = mhq_pkg::CS_RELEASE;
                end
            end
            // Wait for the CCU to drop ack
            mhq_pkg::CS_RELEASE: begin
                if (!i_ccu_ack) begin
                    state_d = mhq_pkg::CS_DONE;
                end
            end
            mhq_pkg::CS_DONE: begin
                state_d = mhq_pkg::CS_IDLE;
            end
            default: begin
                state_d = mhq_pkg::CS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state_q <= mhq_pkg::CS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Address is captured once per fetch
    always_ff @(posedge clk) begin
        if (state_q == mhq_pkg::CS_IDLE && i_head_valid) begin
            addr_q <= i_head_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == mhq_pkg::CS_REQ && i_ccu_ack) begin
            line_q <= i_ccu_data;
        end
    end

    assign o_ccu_req  = (state_q == mhq_pkg::CS_REQ);
    assign o_ccu_addr = addr_q;
    assign o_done     = (state_q == mhq_pkg::CS_DONE);
    assign o_ccu_line = line_q;

    a_req_stable: assert property (@(posedge clk) disable iff (!n_rst)
        (o_ccu_req && !i_ccu_ack) |=> (o_ccu_req && $stable(o_ccu_addr)));

endmodule

//--- hw/mhq_top.sv
/* Miss handling queue top: lookup, execute, pointers and CCU fetch FSM */

`timescale 1ns/1ps

module mhq_top (
    input  logic                             clk,
    input  logic                             n_rst,
    input  logic                             i_req_valid,
    input  mhq_pkg::mhq_req_t                i_req,
    output logic                             o_req_ready,
    output logic                             o_ccu_req,
    output logic [mhq_pkg::ADDR_WIDTH-1:0]   o_ccu_addr,
    input  logic                             i_ccu_ack,
    input  logic [mhq_pkg::LINE_WIDTH-1:0]   i_ccu_data,
    output logic                             o_fill_en,
    output mhq_pkg::mhq_fill_t               o_fill
);

    logic                                ex_en;
    logic                                ex_match;
    logic [mhq_pkg::IDX_WIDTH-1:0]       ex_tag;
    mhq_pkg::mhq_req_t                   ex_req;
    logic [mhq_pkg::MHQ_DEPTH-1:0]       entry_valid;
    logic [mhq_pkg::LINE_ADDR_WIDTH-1:0] entry_addr [mhq_pkg::MHQ_DEPTH];
    logic                                alloc;
    logic                                done;
    logic [mhq_pkg::IDX_WIDTH-1:0]       head_idx;
    logic [mhq_pkg::IDX_WIDTH-1:0]       tail_idx;
    logic                                ptr_full;
    logic                                ptr_empty;
    logic                                head_valid;
    logic [mhq_pkg::ADDR_WIDTH-1:0]      head_addr;
    logic [mhq_pkg::LINE_WIDTH-1:0]      ccu_line;

    mhq_lu lu_i (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_req_valid   (i_req_valid),
        .i_req         (i_req),
        .o_req_ready   (o_req_ready),
        .i_entry_valid (entry_valid),
        .i_entry_addr  (entry_addr),
        .i_tail_idx    (tail_idx),
        .i_full        (ptr_full),
        .o_ex_en       (ex_en),
        .o_ex_match    (ex_match),
        .o_ex_tag      (ex_tag),
        .o_ex_req      (ex_req)
    );

    mhq_ex ex_i (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_ex_en       (ex_en),
        .i_ex_match    (ex_match),
        .i_ex_tag      (ex_tag),
        .i_ex_req      (ex_req),
        .i_head_idx    (head_idx),
        .i_done        (done),
        .i_ccu_line    (ccu_line),
        .o_alloc       (alloc),
        .o_entry_valid (entry_valid),
        .o_entry_addr  (entry_addr),
        .o_head_valid  (head_valid),
        .o_head_addr   (head_addr),
        .o_fill_en     (o_fill_en),
        .o_fill        (o_fill)
    );

    mhq_ptr ptr_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_alloc    (alloc),
        .i_done     (done),
        .o_head_idx (head_idx),
        .o_tail_idx (tail_idx),
        .o_full     (ptr_full),
        .o_empty    (ptr_empty)
    );

    ccu_req_fsm ccu_i (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_head_valid (head_valid),
        .i_head_addr  (head_addr),
        .o_ccu_req    (o_ccu_req),
        .o_ccu_addr   (o_ccu_addr),
        .i_ccu_ack    (i_ccu_ack),
        .i_ccu_data   (i_ccu_data),
        .o_done       (done),
        .o_ccu_line   (ccu_line)
    );

    // Pointer count and entry valid bits must agree
    a_empty_no_head: assert property (@(posedge clk) disable iff (!n_rst)
        ptr_empty |-> !head_valid);

endmodule

//--- verification/mhq_tb.sv
/* Testbench for the miss handling queue: random requests, CCU responder,
   open-line reference model, compare tasks and cycle timeout */

`timescale 1ns/1ps

module mhq_tb;

    localparam int NUM_REQS       = 400;
    localparam int NUM_LINES      = 6;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 8 + 200;

    // One open line of the model with its stored bytes and their mask
    typedef struct packed {
        logic [mhq_pkg::LINE_ADDR_WIDTH-1:0] line_addr;
        logic                                dirty;
        logic [mhq_pkg::LINE_SIZE-1:0]       mask;
        logic [mhq_pkg::LINE_WIDTH-1:0]      data;
    } open_line_t;

    logic                                clk;
    logic                                n_rst;
    logic                                i_req_valid;
    mhq_pkg::mhq_req_t                   i_req;
    logic                                o_req_ready;
    logic                                o_ccu_req;
    logic [mhq_pkg::ADDR_WIDTH-1:0]      o_ccu_addr;
    logic                                i_ccu_ack;
    logic [mhq_pkg::LINE_WIDTH-1:0]      i_ccu_data;
    logic                                o_fill_en;
    mhq_pkg::mhq_fill_t                  o_fill;

    integer                              seed;
    int                                  cycles;
    int                                  sent;
    int                                  stalls;
    int                                  ack_wait;
    logic                                req_seen;
    logic                                offer_active;
    mhq_pkg::mhq_req_t                   offer;
    logic                                held_valid;
    mhq_pkg::mhq_req_t                   held_req;
    logic                                exp_ready;
    open_line_t                          model_q [$];
    logic [mhq_pkg::LINE_ADDR_WIDTH-1:0] line_pool [NUM_LINES];

    mhq_top dut_i (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .o_req_ready (o_req_ready),
        .o_ccu_req   (o_ccu_req),
        .o_ccu_addr  (o_ccu_addr),
        .i_ccu_ack   (i_ccu_ack),
        .i_ccu_data  (i_ccu_data),
        .o_fill_en   (o_fill_en),
        .o_fill      (o_fill)
    );

    always #50 clk = ~clk;

    task automatic end_with_failure();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_logic(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("mismatch %s: got %h expected %h", name, act, exp);
            end_with_failure();
        end
    endtask

    task automatic check_ccu_addr(input logic [mhq_pkg::ADDR_WIDTH-1:0] act,
                                  input logic [mhq_pkg::ADDR_WIDTH-1:0] exp);
        if (act !== exp) begin
            $display("mismatch o_ccu_addr: got %h expected %h", act, exp);
            end_with_failure();
        end
    endtask

    // Dirty flag, line address and line data of a fill record
    task automatic check_fill(input mhq_pkg::mhq_fill_t act, input mhq_pkg::mhq_fill_t exp);
        if (act.dirty !== exp.dirty) begin
            $display("mismatch o_fill.dirty: got %h expected %h", act.dirty, exp.dirty);
            end_with_failure();
        end else if (act.addr !== exp.addr) begin
            $display("mismatch o_fill.addr: got %h expected %h", act.addr, exp.addr);
            end_with_failure();
        end else if (act.data !== exp.data) begin
            $display("mismatch o_fill.data: got %h expected %h", act.data, exp.data);
            end_with_failure();
        end
    endtask

    // Memory contents as seen by the CCU with one byte per address
    function automatic logic [7:0] mem_byte(input logic [mhq_pkg::ADDR_WIDTH-1:0] addr);
        logic [31:0] h;
        h = addr * 32'h9e3779b1;
        return h[31:24] ^ addr[7:0];
    endfunction

    function automatic logic [mhq_pkg::LINE_WIDTH-1:0] mem_line(
        input logic [mhq_pkg::ADDR_WIDTH-1:0] base);
        logic [mhq_pkg::LINE_WIDTH-1:0] line;
        for (int i = 0; i < mhq_pkg::LINE_SIZE; i++) begin
            line[i*8 +: 8] = mem_byte(base + i);
        end
        return line;
    endfunction

    function automatic int find_line(input logic [mhq_pkg::LINE_ADDR_WIDTH-1:0] la);
        for (int i = 0; i < model_q.size(); i++) begin
            if (model_q[i].line_addr == la) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Merge into an open line or open a new one
    task automatic apply_request(input mhq_pkg::mhq_req_t req);
        open_line_t ln;
        int         idx;
        int         pos;
        idx = find_line(req.line_addr);
        if (idx < 0) begin
            ln           = '0;
            ln.line_addr = req.line_addr;
            model_q.push_back(ln);
            idx = model_q.size() - 1;
        end
        ln = model_q[idx];
        if (req.op == mhq_pkg::OP_STORE) begin
            ln.dirty = 1'b1;
            for (int j = 0; j < mhq_pkg::WORD_SIZE; j++) begin
                if (req.byte_sel[j]) begin
                    pos                 = int'(req.offset) + j;
                    ln.data[pos*8 +: 8] = req.wr_data[j*8 +: 8];
                    ln.mask[pos]        = 1'b1;
                end
            end
        end
        model_q[idx] = ln;
    endtask

    task automatic handle_fill();
        open_line_t         ln;
        mhq_pkg::mhq_fill_t exp;
        if (model_q.size() == 0) begin
            $display("fill record appeared while the model had no open line");
            end_with_failure();
        end else begin
            ln        = model_q.pop_front();
            exp       = '0;
            exp.dirty = ln.dirty;
            exp.addr  = {ln.line_addr, {mhq_pkg::OFFSET_WIDTH{1'b0}}};
            exp.data  = mem_line(exp.addr);
            for (int i = 0; i < mhq_pkg::LINE_SIZE; i++) begin
                if (ln.mask[i]) begin
                    exp.data[i*8 +: 8] = ln.data[i*8 +: 8];
                end
            end
            check_fill(o_fill, exp);
        end
    endtask

    // Four-phase responder that acks 0 to 3 cycles after req
    task automatic respond_ccu();
        logic [mhq_pkg::ADDR_WIDTH-1:0] exp_addr;
        if (o_ccu_req && !req_seen) begin
            req_seen = 1'b1;
            ack_wait = $unsigned($random(seed)) % 4;
            if (model_q.size() == 0) begin
                $display("CCU request raised while the model had no open line");
                end_with_failure();
            end else begin
                exp_addr = {model_q[0].line_addr, {mhq_pkg::OFFSET_WIDTH{1'b0}}};
                check_ccu_addr(o_ccu_addr, exp_addr);
            end
        end
        if (!o_ccu_req) begin
            req_seen = 1'b0;
        end
        if (i_ccu_ack && !o_ccu_req) begin
            i_ccu_ack = 1'b0;
        end else if (o_ccu_req && !i_ccu_ack) begin
            if (ack_wait == 0) begin
                i_ccu_ack  = 1'b1;
                i_ccu_data = mem_line(o_ccu_addr);
            end else begin
                ack_wait--;
            end
        end
    endtask

    // An offer stays up until the DUT takes it
    task automatic drive_request();
        logic [31:0] r;
        if (!offer_active && sent < NUM_REQS && ($random(seed) & 3) != 0) begin
            r              = $random(seed);
            offer.op       = r[0] ? mhq_pkg::OP_STORE : mhq_pkg::OP_LOAD;
            offer.line_addr = line_pool[$unsigned($random(seed)) % NUM_LINES];
            offer.offset   = (mhq_pkg::OFFSET_WIDTH)'($unsigned($random(seed)) %
                             (mhq_pkg::LINE_SIZE - mhq_pkg::WORD_SIZE + 1));
            offer.wr_data  = $random(seed);
            offer.byte_sel = r[7:4];
            offer_active   = 1'b1;
        end
        i_req_valid = offer_active;
        i_req       = offer;
        if (offer_active && o_req_ready) begin
            held_valid   = 1'b1;
            held_req     = offer;
            offer_active = 1'b0;
            sent++;
        end
    endtask

    initial begin
        seed         = 32'h673fe988;
        clk          = 1'b0;
        n_rst        = 1'b0;
        i_req_valid  = 1'b0;
        i_req        = '0;
        i_ccu_ack    = 1'b0;
        i_ccu_data   = '0;
        offer        = '0;
        held_req     = '0;
        offer_active = 1'b0;
        held_valid   = 1'b0;
        req_seen     = 1'b0;
        cycles       = 0;
        sent         = 0;
        stalls       = 0;
        ack_wait     = 0;
        for (int k = 0; k < NUM_LINES; k++) begin
            line_pool[k] = (mhq_pkg::LINE_ADDR_WIDTH)'(32'h0001_2340 + 32'h0000_0113 * k);
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_logic("o_fill_en", o_fill_en, 1'b0);
        check_logic("o_ccu_req", o_ccu_req, 1'b0);
        check_logic("o_req_ready", o_req_ready, 1'b1);
        n_rst = 1'b1;

        while (sent < NUM_REQS || offer_active || held_valid || model_q.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("timeout after %0d cycles with %0d lines still open", cycles,
                         model_q.size());
                end_with_failure();
            end else begin
                if (o_fill_en) begin
                    handle_fill();
                end
                // Only a new line on a full queue may be held back
                exp_ready = !held_valid || find_line(held_req.line_addr) >= 0 ||
                            model_q.size() < mhq_pkg::MHQ_DEPTH;
                if (!exp_ready) begin
                    stalls++;
                end
                check_logic("o_req_ready", o_req_ready, exp_ready);
                if (held_valid && o_req_ready) begin
                    apply_request(held_req);
                    held_valid = 1'b0;
                end
                respond_ccu();
                drive_request();
            end
        end

        // Nothing more may come out of a drained queue
        repeat (10) begin
            @(negedge clk);
            check_logic("o_fill_en", o_fill_en, 1'b0);
            check_logic("o_ccu_req", o_ccu_req, 1'b0);
        end

        if (stalls == 0) begin
            $display("no request was ever held back by a full queue");
            end_with_failure();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- project.f
hw/mhq_pkg.sv
hw/mhq_ptr.sv
hw/mhq_lu.sv
hw/mhq_ex.sv
hw/ccu_req_fsm.sv
hw/mhq_top.sv
verification/mhq_tb.sv

//--- Bender.yml
package:
  name: mhq
  authors: []

sources:
  - hw/mhq_pkg.sv
  - hw/mhq_ptr.sv
  - hw/mhq_lu.sv
  - hw/mhq_ex.sv
  - hw/ccu_req_fsm.sv
  - hw/mhq_top.sv
  - target: simulation
    files:
      - verification/mhq_tb.sv
